// File: all.f
+incdir+source
source/sigma_delta_pkg.sv
source/sigma_delta_clock_generator.sv
source/sigma_delta_channel.sv
source/sample_queue.sv
source/apb_sample_port.sv
source/sigma_delta_processor.sv
verification/sigma_delta_checker.sv
verification/sigma_delta_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the sigma-delta testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module sigma_delta_tb \
    --Mdir obj_dir -o sigma_delta_sim \
    -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sigma_delta_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// File: source/apb_sample_port.sv
// APB slave with control, threshold, status and data registers; data reads pop the sample queue
`include "sigma_delta_params.svh"

module apb_sample_port import sigma_delta_pkg::*; (
    input logic clock,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input apb_addr_t paddr,
    input apb_data_t pwdata,
    output apb_data_t prdata,
    output logic pready,
    output logic pslverr,
    input sd_sample_t head,
    input logic empty,
    input queue_level_t level,
    input logic overflow,
    output logic pop,
    output logic enable,
    output sd_value_t [`SD_N_CHANNELS-1:0] high_thresholds,
    output sd_value_t [`SD_N_CHANNELS-1:0] low_thresholds
);

    logic access;
    logic write_access;
    logic ctrl_select;
    logic status_select;
    logic data_select;
    logic mapped;
    logic [`SD_N_CHANNELS-1:0] high_select;
    logic [`SD_N_CHANNELS-1:0] low_select;

    // Sticky status
    logic [`SD_N_CHANNELS-1:0] fault_flags;
    logic overflow_flag;
    logic overflow_q;

    ////////////////////////////////
    // Address decode
    ////////////////////////////////

    // No wait states, access phase completes at once
    assign pready = 1'b1;
    assign access = psel && penable;
    assign write_access = access && pwrite;

    assign ctrl_select = (paddr == `SD_ADDR_CTRL);
    assign status_select = (paddr == `SD_ADDR_STATUS);
    assign data_select = (paddr == `SD_ADDR_DATA);

    // High at base + 8n, low 4 above it
    always_comb begin
        for (int n = 0; n < `SD_N_CHANNELS; n++) begin
            high_select[n] = (paddr == apb_addr_t'(`SD_ADDR_THRESH_BASE + 8 * n));
            low_select[n] = (paddr == apb_addr_t'(`SD_ADDR_THRESH_BASE + 8 * n + 4));
        end
    end

    assign mapped = ctrl_select || status_select || data_select
                    || (|high_select) || (|low_select);
    // Data register is read-only
    assign pslverr = access && (!mapped || (pwrite && data_select));
    assign pop = access && !pwrite && data_select && !empty;

    ////////////////////////////////
    // Read mux
    ////////////////////////////////

    always_comb begin
        prdata = '0;
        if (ctrl_select) begin
            prdata[0] = enable;
        end
        if (status_select) begin
            prdata[`SD_N_CHANNELS-1:0] = fault_flags;
            prdata[2] = overflow_flag;
            prdata[7:4] = level;
        end
        // Empty queue reads as invalid zero
        if (data_select && !empty) begin
            prdata = {1'b1, 13'b0, head.fault, head.channel, head.value};
        end
        for (int n = 0; n < `SD_N_CHANNELS; n++) begin
            if (high_select[n]) begin
                prdata = {16'b0, high_thresholds[n]};
            end
            if (low_select[n]) begin
                prdata = {16'b0, low_thresholds[n]};
            end
        end
    end

    ////////////////////////////////
    // Register writes, sticky flags
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            enable <= 1'b0;
            high_thresholds <= '1;
            low_thresholds <= '0;
            fault_flags <= '0;
            overflow_flag <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            overflow_q <= overflow;
            if (write_access && ctrl_select) begin
                enable <= pwdata[0];
            end
            for (int n = 0; n < `SD_N_CHANNELS; n++) begin
                if (write_access && high_select[n]) begin
                    high_thresholds[n] <= pwdata[15:0];
                end
                if (write_access && low_select[n]) begin
                    low_thresholds[n] <= pwdata[15:0];
                end
            end
            // Write one to clear
            if (write_access && status_select) begin
                fault_flags <= fault_flags & ~pwdata[`SD_N_CHANNELS-1:0];
                if (pwdata[2]) begin
                    overflow_flag <= 1'b0;
                end
            end
            // Faults latch as the sample leaves the queue
            if (pop && head.fault) begin
                fault_flags[head.channel] <= 1'b1;
            end
            if (overflow && !overflow_q) begin
                overflow_flag <= 1'b1;
            end
        end
    end

endmodule

// File: source/sample_queue.sv
// Sample buffer: serializes each channel frame into a circular queue popped by the APB port
`include "sigma_delta_params.svh"

module sample_queue import sigma_delta_pkg::*; (
    input logic clock,
    input logic reset,
    input sd_frame_t frame,
    input logic frame_valid,
    input logic pop,
    output sd_sample_t head,
    output logic empty,
    output queue_level_t level,
    output logic overflow
);

    localparam int POINTER_WIDTH = $clog2(`SD_QUEUE_DEPTH);

    sd_sample_t buffer [`SD_QUEUE_DEPTH];
    logic [POINTER_WIDTH-1:0] write_pointer;
    logic [POINTER_WIDTH-1:0] read_pointer;

    // Serializer
    serial_state_t state;
    sd_channel_t lane;
    sd_frame_t frame_q;

    logic full;
    logic write_request;
    logic write_accept;
    logic pop_accept;

    assign empty = (level == '0);
    assign full = (level == queue_level_t'(`SD_QUEUE_DEPTH));
    assign write_request = (state == serial_emit);
    assign write_accept = write_request && !full;
    assign pop_accept = pop && !empty;
    // Head stays visible until popped
    assign head = buffer[read_pointer];

    ////////////////////////////////
    // Frame serializer FSM
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= serial_idle;
            lane <= '0;
        end else begin
            case (state)
                serial_idle: begin
                    if (frame_valid) begin
                        state <= serial_emit;
                        lane <= '0;
                    end
                end
                serial_emit: begin
                    // One lane per cycle, channel order
                    if (lane == sd_channel_t'(`SD_N_CHANNELS - 1)) begin
                        state <= serial_idle;
                        lane <= '0;
                    end else begin
                        lane <= lane + 1'b1;
                    end
                end
                default: state <= serial_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (frame_valid && state == serial_idle) begin
            frame_q <= frame;
        end
        if (write_accept) begin
            buffer[write_pointer] <= frame_q[lane];
        end
    end

    ////////////////////////////////
    // Pointers, level, overflow
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            write_pointer <= '0;
            read_pointer <= '0;
            level <= '0;
            overflow <= 1'b0;
        end else begin
            if (write_accept) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (pop_accept) begin
                read_pointer <= read_pointer + 1'b1;
            end
            case ({write_accept, pop_accept})
                2'b10: level <= level + 1'b1;
                2'b01: level <= level - 1'b1;
                default: level <= level;
            endcase
            // Dropped sample, flag stays until reset
            if (write_request && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

// File: source/sigma_delta_channel.sv
// One acquisition channel: CIC3 decimation of a modulator bitstream and fault threshold check
`include "sigma_delta_params.svh"

module sigma_delta_channel import sigma_delta_pkg::*; #(
    parameter int CHANNEL_INDEX = 0
) (
    input logic clock,
    input logic reset,
    input logic bit_strobe,
    input logic decim_strobe,
    input logic sd_data,
    input sd_value_t high_threshold,
    input sd_value_t low_threshold,
    output sd_sample_t sample,
    output logic sample_valid
);

    // Registered modulator bit
    logic input_bit;

    // Cascaded integrators, wrap-around arithmetic
    sd_value_t integrator [`SD_CIC_ORDER];
    // Comb delays, updated at the decimated rate
    sd_value_t comb_delay [`SD_CIC_ORDER];
    // Comb differences, combinational
    sd_value_t comb_stage [`SD_CIC_ORDER];

    sd_value_t comb_result;
    logic comb_valid;
    logic fault_detect;

    ////////////////////////////////
    // Comb differences
    ////////////////////////////////

    always_comb begin
        comb_stage[0] = integrator[`SD_CIC_ORDER-1] - comb_delay[0];
        for (int n = 1; n < `SD_CIC_ORDER; n++) begin
            comb_stage[n] = comb_stage[n-1] - comb_delay[n];
        end
    end

    // Outside the window on either side
    assign fault_detect = (comb_result > high_threshold) || (comb_result < low_threshold);

    ////////////////////////////////
    // Filter state
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            input_bit <= 1'b0;
            comb_valid <= 1'b0;
            sample_valid <= 1'b0;
            for (int n = 0; n < `SD_CIC_ORDER; n++) begin
                integrator[n] <= '0;
                comb_delay[n] <= '0;
            end
        end else begin
            input_bit <= sd_data;
            // Pipeline: comb register then compare register
            comb_valid <= decim_strobe;
            sample_valid <= comb_valid;
            if (bit_strobe) begin
                integrator[0] <= integrator[0] + sd_value_t'(input_bit);
                for (int n = 1; n < `SD_CIC_ORDER; n++) begin
                    integrator[n] <= integrator[n] + integrator[n-1];
                end
            end
            if (decim_strobe) begin
                comb_delay[0] <= integrator[`SD_CIC_ORDER-1];
                for (int n = 1; n < `SD_CIC_ORDER; n++) begin
                    comb_delay[n] <= comb_stage[n-1];
                end
            end
        end
    end

    ////////////////////////////////
    // Result and compare registers
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (decim_strobe) begin
            comb_result <= comb_stage[`SD_CIC_ORDER-1];
        end
        if (comb_valid) begin
            sample.channel <= sd_channel_t'(CHANNEL_INDEX);
            sample.value <= comb_result;
            sample.fault <= fault_detect;
        end
    end

endmodule

// File: source/sigma_delta_clock_generator.sv
// Divides the system clock into the modulator bit clock and the bit and decimation strobes
`include "sigma_delta_params.svh"

module sigma_delta_clock_generator (
    input logic clock,
    input logic reset,
    input logic enable,
    output logic bit_strobe,
    output logic decim_strobe,
    output logic sd_clock
);

    localparam int DIVIDE_WIDTH = $clog2(`SD_BIT_DIVIDE);
    localparam int BIT_COUNT_WIDTH = $clog2(`SD_DECIMATION);

    // Position inside the current bit period
    logic [DIVIDE_WIDTH-1:0] divide_count;
    // Bits seen in the current decimation window
    logic [BIT_COUNT_WIDTH-1:0] bit_count;
    // Last system clock of the high half
    logic bit_middle;
    logic divide_wrap;

    assign bit_middle = (divide_count == DIVIDE_WIDTH'(`SD_BIT_DIVIDE / 2 - 1));
    assign divide_wrap = (divide_count == DIVIDE_WIDTH'(`SD_BIT_DIVIDE - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            divide_count <= '0;
            bit_count <= '0;
            sd_clock <= 1'b0;
            bit_strobe <= 1'b0;
            decim_strobe <= 1'b0;
        end else begin
            // Strobes last one cycle
            bit_strobe <= 1'b0;
            decim_strobe <= 1'b0;
            if (enable) begin
                divide_count <= divide_wrap ? '0 : divide_count + 1'b1;
                // High for the first half of the bit period
                sd_clock <= (divide_count < DIVIDE_WIDTH'(`SD_BIT_DIVIDE / 2));
                // Strobe lands mid-bit, well after the modulator edge
                if (bit_middle) begin
                    bit_strobe <= 1'b1;
                    bit_count <= bit_count + 1'b1;
                    decim_strobe <= (bit_count == BIT_COUNT_WIDTH'(`SD_DECIMATION - 1));
                end
            end else begin
                // Counters hold, modulator clock parks low
                sd_clock <= 1'b0;
            end
        end
    end

endmodule

// File: source/sigma_delta_params.svh
// Build-time constants of the sigma-delta peripheral, included by the package and RTL modules
`ifndef SIGMA_DELTA_PARAMS_SVH
`define SIGMA_DELTA_PARAMS_SVH

// Datapath sizing
`define SD_N_CHANNELS 2
`define SD_DECIMATION 32
`define SD_CIC_ORDER 3

// System clocks per modulator bit
`define SD_BIT_DIVIDE 4

// Sample queue entries
`define SD_QUEUE_DEPTH 8

// APB register map
`define SD_ADDR_CTRL 8'h00
`define SD_ADDR_STATUS 8'h04
`define SD_ADDR_THRESH_BASE 8'h08
`define SD_ADDR_DATA 8'h20

`endif

// File: source/sigma_delta_pkg.sv
// Shared types of the sigma-delta peripheral, imported by the modules that use them
`include "sigma_delta_params.svh"

package sigma_delta_pkg;

    ////////////////////////////////
    // Plain vector types
    ////////////////////////////////

    // CIC result, unipolar gain of 32768
    typedef logic [15:0] sd_value_t;
    typedef logic [0:0] sd_channel_t;

    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Queue fill level, 0 up to the full depth
    typedef logic [3:0] queue_level_t;

    ////////////////////////////////
    // Sample and frame
    ////////////////////////////////

    typedef struct packed {
        sd_channel_t channel;
        sd_value_t value;
        // Value above high or below low threshold
        logic fault;
    } sd_sample_t;

    // One lane per channel
    typedef sd_sample_t [`SD_N_CHANNELS-1:0] sd_frame_t;

    // Queue serializer states
    typedef enum logic {
        serial_idle,
        serial_emit
    } serial_state_t;

endpackage

// File: source/sigma_delta_processor.sv
// Top level of the sigma-delta acquisition peripheral with its APB register port
`include "sigma_delta_params.svh"

module sigma_delta_processor import sigma_delta_pkg::*; (
    input logic clock,
    input logic reset,
    input logic [`SD_N_CHANNELS-1:0] data_in,
    output logic clock_out,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input apb_addr_t paddr,
    input apb_data_t pwdata,
    output apb_data_t prdata,
    output logic pready,
    output logic pslverr
);

    // Timing strobes
    logic bit_strobe;
    logic decim_strobe;
    logic enable;

    // Channel results
    sd_frame_t frame;
    logic [`SD_N_CHANNELS-1:0] channel_valid;
    logic frame_valid;

    // Queue to port
    sd_sample_t head;
    logic empty;
    queue_level_t level;
    logic overflow;
    logic pop;

    sd_value_t [`SD_N_CHANNELS-1:0] high_thresholds;
    sd_value_t [`SD_N_CHANNELS-1:0] low_thresholds;

    // All channels share the strobes and finish together
    assign frame_valid = &channel_valid;

    ////////////////////////////////
    // Clock generation
    ////////////////////////////////

    sigma_delta_clock_generator clock_generator_i (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .bit_strobe(bit_strobe),
        .decim_strobe(decim_strobe),
        .sd_clock(clock_out)
    );

    ////////////////////////////////
    // Filter channels
    ////////////////////////////////

    for (genvar n = 0; n < `SD_N_CHANNELS; n++) begin : g_channel
        sigma_delta_channel #(
            .CHANNEL_INDEX(n)
        ) channel_i (
            .clock(clock),
            .reset(reset),
            .bit_strobe(bit_strobe),
            .decim_strobe(decim_strobe),
            .sd_data(data_in[n]),
            .high_threshold(high_thresholds[n]),
            .low_threshold(low_thresholds[n]),
            .sample(frame[n]),
            .sample_valid(channel_valid[n])
        );
    end

    ////////////////////////////////
    // Queue and register port
    ////////////////////////////////

    sample_queue sample_queue_i (
        .clock(clock),
        .reset(reset),
        .frame(frame),
        .frame_valid(frame_valid),
        .pop(pop),
        .head(head),
        .empty(empty),
        .level(level),
        .overflow(overflow)
    );

    apb_sample_port apb_sample_port_i (
        .clock(clock),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .head(head),
        .empty(empty),
        .level(level),
        .overflow(overflow),
        .pop(pop),
        .enable(enable),
        .high_thresholds(high_thresholds),
        .low_thresholds(low_thresholds)
    );

endmodule

// File: verification/sigma_delta_checker.sv
// Testbench monitor that watches APB accesses of the DUT and compares samples and status
`include "sigma_delta_params.svh"

module sigma_delta_checker import sigma_delta_pkg::*; #(
    parameter int SETTLE_SKIP = 5
) (
    input logic clock,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input apb_addr_t paddr,
    input apb_data_t prdata,
    input logic pready,
    input logic pslverr,
    input logic clock_out,
    input logic [127:0] test_name,
    input sd_value_t [1:0] expect_value,
    input logic [1:0] expect_fault,
    input logic sample_check,
    input logic settle_restart,
    input logic expect_invalid,
    input logic status_check,
    input logic [7:0] status_expect,
    input logic [7:0] status_mask,
    input logic expect_error,
    input logic clock_quiet,
    output int value_errors,
    output int other_errors
);
    timeunit 1ns;
    timeprecision 100ps;

    // Samples per channel since the last density change
    int seen [2];
    logic next_channel;
    logic channel;

    initial begin
        value_errors = 0;
        other_errors = 0;
        next_channel = 1'b0;
        seen[0] = 0;
        seen[1] = 0;
    end

    always @(posedge clock) begin
        if (!reset) begin
            if (settle_restart) begin
                seen[0] = 0;
                seen[1] = 0;
            end
            if (clock_quiet && clock_out) begin
                other_errors++;
                $display("%0s: clock_out went high while the modulator clock is stopped",
                         test_name);
            end
            // Access phase with read data already stable
            if (psel && penable) begin
                if (pready !== 1'b1) begin
                    other_errors++;
                    $display("%0s: pready was not high in the access phase", test_name);
                end
                if (pslverr !== expect_error) begin
                    other_errors++;
                    $display("%0s: pslverr was %b on address %h, should be %b",
                             test_name, pslverr, paddr, expect_error);
                end
                if (!pwrite && paddr == `SD_ADDR_DATA) begin
                    if (prdata[31]) begin
                        channel = prdata[16];
                        if (expect_invalid) begin
                            other_errors++;
                            $display("%0s: a sample was read from a queue that should be empty",
                                     test_name);
                        end
                        if (channel !== next_channel) begin
                            value_errors++;
                            $display("ERR %0s channel expected %0d actual %0d",
                                     test_name, next_channel, channel);
                        end
                        // Resync the channel order
                        next_channel = ~channel;
                        if (sample_check && seen[channel] >= SETTLE_SKIP) begin
                            if (prdata[15:0] !== expect_value[channel]) begin
                                value_errors++;
                                $display("ERR %0s value ch%0d expected %h actual %h",
                                         test_name, channel, expect_value[channel],
                                         prdata[15:0]);
                            end
                            if (prdata[17] !== expect_fault[channel]) begin
                                value_errors++;
                                $display("ERR %0s fault ch%0d expected %b actual %b",
                                         test_name, channel, expect_fault[channel],
                                         prdata[17]);
                            end
                        end
                        seen[channel]++;
                    end else if (prdata !== '0) begin
                        other_errors++;
                        $display("%0s: an invalid data read did not return zero", test_name);
                    end
                end
                if (!pwrite && paddr == `SD_ADDR_STATUS && status_check) begin
                    if ((prdata[7:0] & status_mask) !== (status_expect & status_mask)) begin
                        value_errors++;
                        $display("ERR %0s status expected %h actual %h", test_name,
                                 status_expect & status_mask, prdata[7:0] & status_mask);
                    end
                end
            end
        end
    end

endmodule

// File: verification/sigma_delta_tb.sv
// Testbench top with clock, reset, vector file, modulator patterns and APB master tasks
`include "sigma_delta_params.svh"

module sigma_delta_tb import sigma_delta_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SETTLE_SKIP = 5;
    localparam int SAMPLES_PER_TEST = 8;
    localparam int MAX_TESTS = 32;

    logic clock;
    logic reset;
    logic [1:0] data_in;
    logic clock_out;
    logic psel;
    logic penable;
    logic pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic pready;
    logic pslverr;

    // Checker controls
    logic [127:0] test_name;
    sd_value_t [1:0] expect_value;
    logic [1:0] expect_fault;
    logic sample_check;
    logic settle_restart;
    logic expect_invalid;
    logic status_check;
    logic [7:0] status_expect;
    logic [7:0] status_mask;
    logic expect_error;
    logic clock_quiet;
    int value_errors;
    int other_errors;

    // Vector table
    logic [127:0] vec_name [MAX_TESTS];
    int vec_k [MAX_TESTS][2];
    logic [15:0] vec_high [MAX_TESTS][2];
    logic [15:0] vec_low [MAX_TESTS][2];
    logic [15:0] vec_value [MAX_TESTS][2];
    logic [3:0] vec_fault [MAX_TESTS];
    int num_tests;
    int load_errors;
    logic loaded;

    // Modulator pattern state
    int density [2];
    int phase;
    logic clock_out_q;

    sigma_delta_processor sigma_delta_processor_i (
        .clock(clock), .reset(reset), .data_in(data_in), .clock_out(clock_out),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    sigma_delta_checker #(.SETTLE_SKIP(SETTLE_SKIP)) checker_i (
        .clock(clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .clock_out(clock_out),
        .test_name(test_name), .expect_value(expect_value), .expect_fault(expect_fault),
        .sample_check(sample_check), .settle_restart(settle_restart),
        .expect_invalid(expect_invalid), .status_check(status_check),
        .status_expect(status_expect), .status_mask(status_mask),
        .expect_error(expect_error), .clock_quiet(clock_quiet),
        .value_errors(value_errors), .other_errors(other_errors)
    );

    always #20 clock = ~clock;

    ////////////////////////////////
    // Modulator bitstreams
    ////////////////////////////////

    // k ones spread evenly over 32 bits
    function automatic logic modulator_bit(int bit_phase, int k);
        return ((bit_phase * k) % 32) < k;
    endfunction

    // New bit on every rising clock_out
    always @(posedge clock) begin
        clock_out_q <= clock_out;
        if (clock_out && !clock_out_q) begin
            data_in <= {modulator_bit(phase, density[1]), modulator_bit(phase, density[0])};
            phase <= (phase + 1) % 32;
        end
    end

    ////////////////////////////////
    // APB master
    ////////////////////////////////

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic err);
        @(posedge clock);
        psel <= 1'b1;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        expect_error <= err;
        @(posedge clock);
        penable <= 1'b1;
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
        expect_error <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, input logic err, output apb_data_t data);
        @(posedge clock);
        psel <= 1'b1;
        pwrite <= 1'b0;
        paddr <= addr;
        expect_error <= err;
        @(posedge clock);
        penable <= 1'b1;
        // Sample in the middle of the access phase
        @(negedge clock);
        data = prdata;
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
        expect_error <= 1'b0;
    endtask

    task automatic check_status(input logic [7:0] expect_bits, input logic [7:0] mask);
        apb_data_t data;
        status_expect <= expect_bits;
        status_mask <= mask;
        status_check <= 1'b1;
        apb_read(`SD_ADDR_STATUS, 1'b0, data);
        status_check <= 1'b0;
    endtask

    // Pops until the queue reads invalid
    task automatic drain_queue();
        apb_data_t data;
        data = 32'h8000_0000;
        while (data[31]) begin
            apb_read(`SD_ADDR_DATA, 1'b0, data);
        end
    endtask

    ////////////////////////////////
    // Vector file
    ////////////////////////////////

    task automatic load_vectors();
        int fd;
        int fields;
        string line;
        fd = $fopen("verification/sigma_delta_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file");
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 2 && line.getc(0) != 8'h23) begin
                    fields = $sscanf(line, "%s %d %d %h %h %h %h %h %h %h",
                        vec_name[num_tests], vec_k[num_tests][0], vec_k[num_tests][1],
                        vec_high[num_tests][0], vec_low[num_tests][0],
                        vec_high[num_tests][1], vec_low[num_tests][1],
                        vec_value[num_tests][0], vec_value[num_tests][1],
                        vec_fault[num_tests]);
                    if (fields == 10) begin
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
        if (num_tests == 0) begin
            $display("No test vectors were read from the vector file");
            load_errors++;
        end
    endtask

    // Reads samples until each channel has its count and clears status once unsettled ones pass
    task automatic read_samples(input int per_channel);
        apb_data_t data;
        int got [2];
        logic cleared;
        got[0] = 0;
        got[1] = 0;
        cleared = 1'b0;
        while (got[0] < per_channel || got[1] < per_channel) begin
            apb_read(`SD_ADDR_DATA, 1'b0, data);
            if (data[31]) begin
                got[data[16]]++;
            end
            if (!cleared && got[0] >= SETTLE_SKIP && got[1] >= SETTLE_SKIP) begin
                apb_write(`SD_ADDR_STATUS, 32'h3, 1'b0);
                cleared = 1'b1;
            end
        end
    endtask

    task automatic run_vector(input int t);
        @(posedge clock);
        test_name <= vec_name[t];
        expect_value <= {vec_value[t][1], vec_value[t][0]};
        expect_fault <= vec_fault[t][1:0];
        for (int n = 0; n < 2; n++) begin
            apb_write(`SD_ADDR_THRESH_BASE + 8 * n, {16'b0, vec_high[t][n]}, 1'b0);
            apb_write(`SD_ADDR_THRESH_BASE + 8 * n + 4, {16'b0, vec_low[t][n]}, 1'b0);
        end
        @(posedge clock);
        density[0] <= vec_k[t][0];
        density[1] <= vec_k[t][1];
        settle_restart <= 1'b1;
        sample_check <= 1'b1;
        @(posedge clock);
        settle_restart <= 1'b0;
        read_samples(SAMPLES_PER_TEST);
        sample_check <= 1'b0;
        // Sticky flags come from settled samples and a write of one clears them
        check_status({6'b0, vec_fault[t][1:0]}, 8'h03);
        apb_write(`SD_ADDR_STATUS, 32'h3, 1'b0);
        check_status(8'h00, 8'h03);
    endtask

    ////////////////////////////////
    // Watchdog
    ////////////////////////////////

    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(num_tests + 4) * 8 * 128 * 40 * 3;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////

    initial begin
        apb_data_t data;
        clock = 1'b0;
        reset = 1'b1;
        data_in = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        test_name = "reset_state";
        expect_value = '0;
        expect_fault = '0;
        sample_check = 1'b0;
        settle_restart = 1'b0;
        expect_invalid = 1'b1;
        status_check = 1'b0;
        status_expect = '0;
        status_mask = '0;
        expect_error = 1'b0;
        clock_quiet = 1'b1;
        density[0] = 0;
        density[1] = 0;
        phase = 0;
        clock_out_q = 1'b0;
        num_tests = 0;
        load_errors = 0;
        loaded = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        // Idle after reset with no modulator clock
        check_status(8'h00, 8'hff);
        apb_read(`SD_ADDR_DATA, 1'b0, data);
        repeat (200) @(posedge clock);
        clock_quiet <= 1'b0;
        expect_invalid <= 1'b0;
        apb_write(`SD_ADDR_CTRL, 32'h1, 1'b0);

        for (int t = 0; t < num_tests; t++) begin
            run_vector(t);
        end

        // Disable stops clock_out and the samples
        test_name <= "disable_stop";
        apb_write(`SD_ADDR_CTRL, 32'h0, 1'b0);
        repeat (3) @(posedge clock);
        clock_quiet <= 1'b1;
        drain_queue();
        expect_invalid <= 1'b1;
        repeat (4) begin
            repeat (100) @(posedge clock);
            apb_read(`SD_ADDR_DATA, 1'b0, data);
        end
        expect_invalid <= 1'b0;
        clock_quiet <= 1'b0;
        apb_write(`SD_ADDR_CTRL, 32'h1, 1'b0);

        // Unread queue fills and drops samples
        test_name <= "overflow";
        repeat (6 * 128 + 50) @(posedge clock);
        apb_write(`SD_ADDR_CTRL, 32'h0, 1'b0);
        check_status(8'h84, 8'hf4);
        drain_queue();
        apb_write(`SD_ADDR_STATUS, 32'h4, 1'b0);
        check_status(8'h00, 8'hf4);

        // Bus errors
        test_name <= "bus_error";
        apb_read(8'h40, 1'b1, data);
        apb_write(`SD_ADDR_DATA, 32'h1234, 1'b1);
        apb_write(8'h3c, 32'h0, 1'b1);
        repeat (4) @(posedge clock);

        $display("Errors: %0d value, %0d other, %0d vector file",
                 value_errors, other_errors, load_errors);
        if (value_errors == 0 && other_errors == 0 && load_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verification/sigma_delta_vectors.txt
# name k0 k1 high0 low0 high1 low1 value0 value1 faults (hex thresholds and values)
# value is k x 1024, faults bit 0 is channel 0 and bit 1 is channel 1
idle_zero 0 0 ffff 0000 ffff 0000 0000 0000 0
half_quarter 16 8 ffff 0000 ffff 0000 4000 2000 0
full_scale 32 1 ffff 0000 ffff 0000 8000 0400 0
high_fault_ch0 24 12 5000 0000 ffff 0000 6000 3000 1
low_fault_ch1 12 3 ffff 0000 ffff 1000 3000 0c00 2
both_faults 4 20 ffff 2000 4000 0000 1000 5000 3
edge_exact 8 9 2000 2000 2000 0000 2000 2400 2
odd_density 7 31 ffff 1c00 7c00 7c00 1c00 7c00 0
max_fault 32 0 7fff 0000 ffff 0001 8000 0000 3
